// ==== files.f ====
+incdir+design
design/kbd_pkg.sv
design/scancode_map.sv
design/key_event_fsm.sv
design/key_matrix_regs.sv
design/io_read_port.sv
design/keyboard_matrix.sv
dv/kbd_checker.sv
dv/keyboard_matrix_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the keyboard matrix testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module keyboard_matrix_tb -o keyboard_matrix_sim \
    && ./obj_dir/keyboard_matrix_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -qx "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== dv/keyboard_matrix_tb.sv ====
`include "kbd_config.svh"

module keyboard_matrix_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import kbd_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_EVENTS = 36;      // upper bound of directed steps
    localparam int RANDOM_EVENTS   = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * (DIRECTED_EVENTS + RANDOM_EVENTS);

    logic                   clk = 1'b0;
    logic                   nReset;
    logic                   key_req;
    logic                   key_break;
    logic                   key_ext;
    scan_code_t             scan_code;
    logic                   key_ack;
    logic                   io_req;
    logic [`KBD_ADDR_W-1:0] io_addr;
    logic                   io_ack;
    row_data_t              io_data;

    row_data_t              model [`KBD_ROWS];     // expected key status
    logic [`KBD_ADDR_W-1:0] chk_addr [$];          // pending reads
    row_data_t              chk_exp [$];
    logic                   chk_pending = 1'b0;    // main -> compare process
    string                  test_name = "none";
    int                     error_count = 0;
    logic [31:0]            lcg_state = 32'h4bdf_f17b;

    // last pick list entry has no key
    scan_code_t list_code [10] = '{8'h1c, 8'h76, 8'h5a, 8'h29, 8'h3a,
                                   8'h11, 8'h11, 8'h75, 8'h74, 8'h77};
    logic       list_ext  [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                                   1'b0, 1'b1, 1'b1, 1'b1, 1'b0};

    always #10 clk = ~clk;     // 20 ns period

    keyboard_matrix dut_i (
        .clk, .nReset, .key_req, .key_break, .key_ext, .scan_code, .key_ack,
        .io_req, .io_addr, .io_ack, .io_data
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // row/bit for each {ext, code} pair in use
    function automatic void ref_apply(input scan_code_t code, input logic ext,
                                      input logic brk);
        logic     hit;
        row_idx_t r;
        col_idx_t c;
        hit = 1'b1;
        r   = '0;
        c   = '0;
        case ({ext, code})
            {1'b0, 8'h1c}: begin r = 3'd4; c = 3'd6; end   // a
            {1'b0, 8'h76}: begin r = 3'd0; c = 3'd7; end   // esc
            {1'b0, 8'h5a}: begin r = 3'd3; c = 3'd0; end   // enter
            {1'b0, 8'h29}: begin r = 3'd7; c = 3'd3; end   // space
            {1'b0, 8'h3a}: begin r = 3'd6; c = 3'd0; end   // m
            {1'b0, 8'h11}: begin r = 3'd3; c = 3'd2; end   // lalt
            {1'b1, 8'h11}: begin r = 3'd3; c = 3'd1; end   // ralt
            {1'b1, 8'h75}: begin r = 3'd5; c = 3'd1; end   // up
            {1'b1, 8'h74}: begin r = 3'd7; c = 3'd0; end   // right
            default:       hit = 1'b0;                      // 0x77, ext 0x1c
        endcase
        if (hit) begin
            model[r][c] = !brk;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // driver and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_row(input string name, input row_data_t expected,
                             input row_data_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch in %s: expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "row data mismatch");
        end
    endtask

    // one four-phase read with data taken while ack is high
    task automatic io_read(input logic [`KBD_ADDR_W-1:0] addr, output row_data_t data);
        @(negedge clk);
        io_addr = addr;
        io_req  = 1'b1;
        @(negedge clk);
        while (!io_ack) @(negedge clk);
        data   = io_data;
        io_req = 1'b0;
        @(negedge clk);
        while (io_ack) @(negedge clk);
    endtask

    task automatic run_checks();
        chk_pending = 1'b1;
        wait (!chk_pending);    // compare process drained the queue
    endtask

    task automatic queue_full_readback();
        for (int r = 0; r < `KBD_ROWS; r++) begin
            chk_addr.push_back(16'(`KBD_IO_BASE + r));
            chk_exp.push_back(model[row_idx_t'(r)]);
        end
    endtask

    task automatic check_addr(input string name, input logic [`KBD_ADDR_W-1:0] addr,
                              input row_data_t expected);
        test_name = name;
        chk_addr.push_back(addr);
        chk_exp.push_back(expected);
        run_checks();
    endtask

    // key handshake, then model update and full row check
    task automatic send_event(input string name, input scan_code_t code,
                              input logic ext, input logic brk);
        test_name = name;
        @(negedge clk);
        scan_code = code;
        key_ext   = ext;
        key_break = brk;
        key_req   = 1'b1;
        @(negedge clk);
        while (!key_ack) @(negedge clk);
        key_req = 1'b0;
        @(negedge clk);
        while (key_ack) @(negedge clk);     // matrix already updated here
        ref_apply(code, ext, brk);
        queue_full_readback();
        run_checks();
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process that owns the read channel
    //////////////////////////////////////////////////////////////////////

    initial begin : compare_proc
        logic [`KBD_ADDR_W-1:0] addr;
        row_data_t              expected;
        row_data_t              actual;
        io_req  = 1'b0;
        io_addr = '0;
        forever begin
            wait (chk_pending);
            while (chk_addr.size() > 0) begin
                addr     = chk_addr.pop_front();
                expected = chk_exp.pop_front();
                io_read(addr, actual);
                check_row(test_name, expected, actual);
            end
            chk_pending = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_proc
        logic [3:0] idx;
        logic       brk;
        nReset    = 1'b0;
        key_req   = 1'b0;
        key_break = 1'b0;
        key_ext   = 1'b0;
        scan_code = '0;
        for (int r = 0; r < `KBD_ROWS; r++) begin
            model[row_idx_t'(r)] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        nReset = 1'b1;

        test_name = "reset rows";             // all rows clear
        queue_full_readback();
        run_checks();

        // make then break for single keys
        send_event("a make", 8'h1c, 1'b0, 1'b0);
        send_event("a break", 8'h1c, 1'b0, 1'b1);
        send_event("esc make", 8'h76, 1'b0, 1'b0);
        send_event("esc break", 8'h76, 1'b0, 1'b1);
        send_event("enter make", 8'h5a, 1'b0, 1'b0);
        send_event("enter break", 8'h5a, 1'b0, 1'b1);
        send_event("space make", 8'h29, 1'b0, 1'b0);
        send_event("space break", 8'h29, 1'b0, 1'b1);
        send_event("m make", 8'h3a, 1'b0, 1'b0);
        send_event("m break", 8'h3a, 1'b0, 1'b1);
        send_event("lalt make", 8'h11, 1'b0, 1'b0);
        send_event("lalt break", 8'h11, 1'b0, 1'b1);

        // 0x11 plain and e0 held at once
        send_event("alt plain make", 8'h11, 1'b0, 1'b0);
        send_event("alt ext make", 8'h11, 1'b1, 1'b0);
        send_event("alt plain break", 8'h11, 1'b0, 1'b1);
        send_event("alt ext break", 8'h11, 1'b1, 1'b1);
        send_event("up make", 8'h75, 1'b1, 1'b0);
        send_event("up break", 8'h75, 1'b1, 1'b1);
        send_event("right make", 8'h74, 1'b1, 1'b0);
        send_event("right break", 8'h74, 1'b1, 1'b1);

        // codes with no key must leave a held
        send_event("hold a", 8'h1c, 1'b0, 1'b0);
        send_event("unmapped make", 8'h77, 1'b0, 1'b0);
        send_event("ext a break", 8'h1c, 1'b1, 1'b1);
        send_event("ext a make", 8'h1c, 1'b1, 1'b0);
        send_event("release a", 8'h1c, 1'b0, 1'b1);

        // address window with keys held in rows 0, 3 and 7
        // rows 0 and 7 non-zero so a wrapped decode shows up
        send_event("hold esc", 8'h76, 1'b0, 1'b0);
        send_event("hold enter", 8'h5a, 1'b0, 1'b0);
        send_event("hold space", 8'h29, 1'b0, 1'b0);
        check_addr("addr 0x20", 16'h0020, 8'h00);
        check_addr("addr 0x0f", 16'h000f, 8'h00);
        check_addr("addr 0xab13", 16'hab13, model[3]);
        send_event("release esc", 8'h76, 1'b0, 1'b1);
        send_event("release enter", 8'h5a, 1'b0, 1'b1);
        send_event("release space", 8'h29, 1'b0, 1'b1);

        // random make/break over the pick list
        for (int i = 0; i < RANDOM_EVENTS; i++) begin
            lcg_state = lcg_next(lcg_state);
            idx       = 4'((lcg_state >> 16) % 32'd10);
            brk       = lcg_state[15];
            send_event($sformatf("random %0d", i), list_code[idx], list_ext[idx], brk);
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog_proc
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout in %s: a handshake hung and the run did not complete", test_name);
        $display("Finished with errors");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== dv/kbd_checker.sv ====
module kbd_checker (
    input logic               clk,
    input logic               nReset,
    input logic               key_req,
    input logic               key_ack,
    input logic               io_req,
    input logic               io_ack,
    input kbd_pkg::row_data_t io_data
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // four-phase handshake rules
    //////////////////////////////////////////////////////////////////////

    // ack drops only on an edge that saw req low
    key_ack_release: assert property (@(posedge clk) disable iff (!nReset)
        $fell(key_ack) |-> !$past(key_req))
        else $error("key_ack fell while key_req was still high");

    io_ack_release: assert property (@(posedge clk) disable iff (!nReset)
        $fell(io_ack) |-> !$past(io_req))
        else $error("io_ack fell while io_req was still high");

    // requester must wait for ack before letting go
    key_req_hold: assert property (@(posedge clk) disable iff (!nReset)
        $fell(key_req) |-> key_ack)
        else $error("key_req dropped before key_ack was seen");

    // read data frozen for the whole ack phase
    io_data_hold: assert property (@(posedge clk) disable iff (!nReset)
        (io_ack && $past(io_ack)) |-> $stable(io_data))
        else $error("io_data changed while io_ack was high");

endmodule

bind keyboard_matrix kbd_checker chk_i (
    .clk, .nReset, .key_req, .key_ack, .io_req, .io_ack, .io_data
);

// ==== design/keyboard_matrix.sv ====
`include "kbd_config.svh"

module keyboard_matrix (
    input  logic                   clk,
    input  logic                   nReset,
    // key event channel
    input  logic                   key_req,
    input  logic                   key_break,   // f0 prefix seen
    input  logic                   key_ext,     // e0 prefix seen
    input  kbd_pkg::scan_code_t    scan_code,
    output logic                   key_ack,
    // host read channel
    input  logic                   io_req,
    input  logic [`KBD_ADDR_W-1:0] io_addr,
    output logic                   io_ack,
    output kbd_pkg::row_data_t     io_data
);
    import kbd_pkg::*;

    logic      map_hit;
    row_idx_t  map_row;
    col_idx_t  map_col;
    logic      key_strobe;
    row_idx_t  rd_row;
    row_data_t rd_data;

    //////////////////////////////////////////////////////////////////////
    // key path
    //////////////////////////////////////////////////////////////////////

    scancode_map map_i (.scan_code, .key_ext, .map_hit, .map_row, .map_col);

    key_event_fsm evt_i (.clk, .nReset, .key_req, .key_ack, .key_strobe);

    key_matrix_regs mtx_i (
        .clk, .nReset, .key_strobe, .map_hit, .key_break,
        .map_row, .map_col, .rd_row, .rd_data
    );

    //////////////////////////////////////////////////////////////////////
    // host path
    //////////////////////////////////////////////////////////////////////

    io_read_port io_i (
        .clk, .nReset, .io_req, .io_addr, .rd_data,
        .io_ack, .rd_row, .io_data
    );

endmodule

// ==== design/io_read_port.sv ====
`include "kbd_config.svh"

module io_read_port (
    input  logic                   clk,
    input  logic                   nReset,
    input  logic                   io_req,
    input  logic [`KBD_ADDR_W-1:0] io_addr,     // upper byte ignored
    input  kbd_pkg::row_data_t     rd_data,     // selected matrix row
    output logic                   io_ack,
    output kbd_pkg::row_idx_t      rd_row,
    output kbd_pkg::row_data_t     io_data      // held until next read
);
    import kbd_pkg::*;

    localparam logic [7:0] IO_BASE = `KBD_IO_BASE;

    hs_state_t  state;
    logic [7:0] addr_off;      // low byte relative to row 0
    logic       in_window;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign addr_off  = io_addr[7:0] - IO_BASE;     // wraps below base
    assign in_window = (addr_off < 8'(`KBD_ROWS));
    assign rd_row    = row_idx_t'(addr_off);

    //////////////////////////////////////////////////////////////////////
    // four-phase read handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            state   <= IDLE;
            io_data <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (io_req) begin
                        state   <= ACKED;
                        // data valid together with ack
                        io_data <= in_window ? rd_data : '0;
                    end
                end
                ACKED: begin
                    if (!io_req) begin
                        state <= IDLE;          // io_data keeps last value
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign io_ack = (state == ACKED);

endmodule

// ==== design/key_matrix_regs.sv ====
`include "kbd_config.svh"

module key_matrix_regs (
    input  logic              clk,
    input  logic              nReset,
    input  logic              key_strobe,   // from key_event_fsm
    input  logic              map_hit,      // code is in the table
    input  logic              key_break,    // 1 = release, 0 = press
    input  kbd_pkg::row_idx_t map_row,
    input  kbd_pkg::col_idx_t map_col,
    input  kbd_pkg::row_idx_t rd_row,       // read select from the io port
    output kbd_pkg::row_data_t rd_data
);
    import kbd_pkg::*;

    row_data_t key_status [`KBD_ROWS];      // 1 = held

    //////////////////////////////////////////////////////////////////////
    // bit set / clear
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            for (int r = 0; r < `KBD_ROWS; r++) begin
                key_status[r] <= '0;            // all keys up
            end
        end else if (key_strobe && map_hit) begin
            // only the addressed bit moves
            key_status[map_row][map_col] <= !key_break;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // row read
    //////////////////////////////////////////////////////////////////////

    // combinational, io port registers the result
    // a read on the update edge still sees the old row
    assign rd_data = key_status[rd_row];

endmodule

// ==== design/key_event_fsm.sv ====
module key_event_fsm (
    input  logic clk,
    input  logic nReset,
    input  logic key_req,      // level req from the ps/2 decoder
    output logic key_ack,
    output logic key_strobe    // one cycle per accepted event
);
    import kbd_pkg::*;

    hs_state_t state;

    //////////////////////////////////////////////////////////////////////
    // four-phase handshake
    //////////////////////////////////////////////////////////////////////

    // idle -> acked on req, back to idle once req is released
    always_ff @(posedge clk or negedge nReset) begin
        if (!nReset) begin
            state      <= IDLE;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= 1'b0;                  // default, single pulse
            case (state)
                IDLE: begin
                    if (key_req) begin
                        state      <= ACKED;
                        key_strobe <= 1'b1;      // matrix updates next edge
                    end
                end
                ACKED: begin
                    // held req is ignored here, no second strobe
                    if (!key_req) begin
                        state <= IDLE;           // ack drops with it
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ack is just the state bit
    assign key_ack = (state == ACKED);

endmodule

// ==== design/scancode_map.sv ====
module scancode_map (
    input  kbd_pkg::scan_code_t scan_code,
    input  logic                key_ext,     // e0 prefix seen
    output logic                map_hit,
    output kbd_pkg::row_idx_t   map_row,
    output kbd_pkg::col_idx_t   map_col
);
    import kbd_pkg::*;

    // {row, col} per key, col 7 = leftmost
    always_comb begin
        map_hit = 1'b1;                      // cleared by default arms
        {map_row, map_col} = {3'd0, 3'd0};
        if (key_ext) begin
            // extended keys only, standard codes miss here
            case (scan_code)
                8'h11:   {map_row, map_col} = {3'd3, 3'd1};  // ralt
                8'h75:   {map_row, map_col} = {3'd5, 3'd1};  // up
                8'h14:   {map_row, map_col} = {3'd7, 3'd4};  // rctrl
                8'h6b:   {map_row, map_col} = {3'd7, 3'd2};  // left
                8'h72:   {map_row, map_col} = {3'd7, 3'd1};  // down
                8'h74:   {map_row, map_col} = {3'd7, 3'd0};  // right
                default: map_hit = 1'b0;
            endcase
        end else begin
            case (scan_code)
                // row 0: esc ` 1 2 3 4 5 6
                8'h76:   {map_row, map_col} = {3'd0, 3'd7};
                8'h0e:   {map_row, map_col} = {3'd0, 3'd6};
                8'h16:   {map_row, map_col} = {3'd0, 3'd5};
                8'h1e:   {map_row, map_col} = {3'd0, 3'd4};
                8'h26:   {map_row, map_col} = {3'd0, 3'd3};
                8'h25:   {map_row, map_col} = {3'd0, 3'd2};
                8'h2e:   {map_row, map_col} = {3'd0, 3'd1};
                8'h36:   {map_row, map_col} = {3'd0, 3'd0};
                // row 1: 7 8 9 0 - = bksp f1
                8'h3d:   {map_row, map_col} = {3'd1, 3'd7};
                8'h3e:   {map_row, map_col} = {3'd1, 3'd6};
                8'h46:   {map_row, map_col} = {3'd1, 3'd5};
                8'h45:   {map_row, map_col} = {3'd1, 3'd4};
                8'h4e:   {map_row, map_col} = {3'd1, 3'd3};
                8'h55:   {map_row, map_col} = {3'd1, 3'd2};
                8'h66:   {map_row, map_col} = {3'd1, 3'd1};
                8'h05:   {map_row, map_col} = {3'd1, 3'd0};
                // row 2: tab q w e r t y u
                8'h0d:   {map_row, map_col} = {3'd2, 3'd7};
                8'h15:   {map_row, map_col} = {3'd2, 3'd6};
                8'h1d:   {map_row, map_col} = {3'd2, 3'd5};
                8'h24:   {map_row, map_col} = {3'd2, 3'd4};
                8'h2d:   {map_row, map_col} = {3'd2, 3'd3};
                8'h2c:   {map_row, map_col} = {3'd2, 3'd2};
                8'h35:   {map_row, map_col} = {3'd2, 3'd1};
                8'h3c:   {map_row, map_col} = {3'd2, 3'd0};
                // row 3: i o p [ ] lalt (ralt) enter
                8'h43:   {map_row, map_col} = {3'd3, 3'd7};
                8'h44:   {map_row, map_col} = {3'd3, 3'd6};
                8'h4d:   {map_row, map_col} = {3'd3, 3'd5};
                8'h54:   {map_row, map_col} = {3'd3, 3'd4};
                8'h5b:   {map_row, map_col} = {3'd3, 3'd3};
                8'h11:   {map_row, map_col} = {3'd3, 3'd2};  // lalt, bit 1 is ralt
                8'h5a:   {map_row, map_col} = {3'd3, 3'd0};
                // row 4: lshift a s d f g h j
                8'h12:   {map_row, map_col} = {3'd4, 3'd7};
                8'h1c:   {map_row, map_col} = {3'd4, 3'd6};
                8'h1b:   {map_row, map_col} = {3'd4, 3'd5};
                8'h23:   {map_row, map_col} = {3'd4, 3'd4};
                8'h2b:   {map_row, map_col} = {3'd4, 3'd3};
                8'h34:   {map_row, map_col} = {3'd4, 3'd2};
                8'h33:   {map_row, map_col} = {3'd4, 3'd1};
                8'h3b:   {map_row, map_col} = {3'd4, 3'd0};
                // row 5: k l ; ' # f2 (up) rshift
                8'h42:   {map_row, map_col} = {3'd5, 3'd7};
                8'h4b:   {map_row, map_col} = {3'd5, 3'd6};
                8'h4c:   {map_row, map_col} = {3'd5, 3'd5};
                8'h52:   {map_row, map_col} = {3'd5, 3'd4};
                8'h5d:   {map_row, map_col} = {3'd5, 3'd3};
                8'h06:   {map_row, map_col} = {3'd5, 3'd2};
                8'h59:   {map_row, map_col} = {3'd5, 3'd0};
                // row 6: lctrl z x c v b n m
                8'h14:   {map_row, map_col} = {3'd6, 3'd7};
                8'h1a:   {map_row, map_col} = {3'd6, 3'd6};
                8'h22:   {map_row, map_col} = {3'd6, 3'd5};
                8'h21:   {map_row, map_col} = {3'd6, 3'd4};
                8'h2a:   {map_row, map_col} = {3'd6, 3'd3};
                8'h32:   {map_row, map_col} = {3'd6, 3'd2};
                8'h31:   {map_row, map_col} = {3'd6, 3'd1};
                8'h3a:   {map_row, map_col} = {3'd6, 3'd0};
                // row 7: , . / space, low bits are the extended keys
                8'h41:   {map_row, map_col} = {3'd7, 3'd7};
                8'h49:   {map_row, map_col} = {3'd7, 3'd6};
                8'h4a:   {map_row, map_col} = {3'd7, 3'd5};
                8'h29:   {map_row, map_col} = {3'd7, 3'd3};
                default: map_hit = 1'b0;             // unknown code, ignored
            endcase
        end
    end

endmodule

// ==== design/kbd_pkg.sv ====
`include "kbd_config.svh"

package kbd_pkg;

    ////////////////////////////////////////////////////////////////////
    // key matrix types
    ////////////////////////////////////////////////////////////////////

    typedef logic [`KBD_CODE_W-1:0] scan_code_t;        // one ps/2 code byte

    typedef logic [$clog2(`KBD_ROWS)-1:0] row_idx_t;    // matrix row number

    // bit number in a row, 7 is the leftmost key
    typedef logic [$clog2(`KBD_COLS)-1:0] col_idx_t;

    typedef logic [`KBD_COLS-1:0] row_data_t;           // 1 = key held down

    ////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////

    // shared by the key channel and the i/o read channel
    typedef enum logic {
        IDLE  = 1'b0,   // waiting for req
        ACKED = 1'b1    // ack high, waiting for req to drop
    } hs_state_t;

endpackage

// ==== design/kbd_config.svh ====
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// matrix geometry
`define KBD_ROWS     8         // rows in the key matrix
`define KBD_COLS     8         // keys per row, one bit each

// ps/2 side
`define KBD_CODE_W   8         // decoded scan code byte

// host i/o side
`define KBD_ADDR_W   16        // full i/o address, only low byte decoded
`define KBD_IO_BASE  8'h10     // low byte of row 0, rows follow upward

// row window is base .. base+KBD_ROWS-1, so 0x10..0x17

`endif
